// File: hw/hci_queue_pkg.sv
// Shared widths and encodings for single 32-bit word CSR access only
package hci_queue_pkg;

  // Bus and register widths
  localparam int unsigned csr_data_width = 32;
  localparam int unsigned csr_addr_width = 8;
  localparam int unsigned thld_width = 8;

  // Register byte offsets inside the CSR window
  typedef enum logic [csr_addr_width-1:0] {
    REG_CMD_PORT        = 8'h00,
    REG_RESP_PORT       = 8'h04,
    REG_QUEUE_THLD_CTRL = 8'h08,
    REG_QUEUE_STATUS    = 8'h0C,
    REG_RESET_CONTROL   = 8'h10
  } csr_reg_e;

  // AHB slave phases
  typedef enum logic [1:0] {
    PH_IDLE,
    PH_ACCESS,
    PH_ERR1,
    PH_ERR2
  } ahb_phase_e;

  // Both ready thresholds come out of reset at one entry
  localparam logic [thld_width-1:0] thld_reset_value = thld_width'(1);

endpackage

// File: hw/ahb_csr_bridge.sv
// Single AHB-Lite transfers only, no bursts or strobes, and one wait state ahead of an ERROR
`timescale 1ns/1ps

module ahb_csr_bridge (
  input  logic                                     hclk_i,
  input  logic                                     rst_n_i,
  input  logic                                     hsel_i,
  input  logic [31:0]                              haddr_i,
  input  logic [1:0]                               htrans_i,
  input  logic                                     hwrite_i,
  input  logic [2:0]                               hsize_i,
  input  logic [hci_queue_pkg::csr_data_width-1:0] hwdata_i,
  input  logic                                     hready_i,
  input  logic [hci_queue_pkg::csr_data_width-1:0] csr_rdata_i,
  input  logic                                     csr_err_i,
  output logic [hci_queue_pkg::csr_data_width-1:0] hrdata_o,
  output logic                                     hreadyout_o,
  output logic                                     hresp_o,
  output logic                                     csr_req_o,
  output logic                                     csr_we_o,
  output logic [hci_queue_pkg::csr_addr_width-1:0] csr_addr_o,
  output logic [hci_queue_pkg::csr_data_width-1:0] csr_wdata_o
);
  import hci_queue_pkg::*;

  ahb_phase_e                phase_q;
  ahb_phase_e                phase_d;
  logic [csr_addr_width-1:0] addr_q;
  logic                      write_q;
  logic                      bad_q;
  logic                      accept;
  logic                      xfer_err;

  // NONSEQ or SEQ while selected, never during the first error cycle
  assign accept = hsel_i && hready_i && htrans_i[1] && hreadyout_o;

  // Misaligned or oversized transfers never reach the register block
  assign xfer_err = bad_q || csr_err_i;

  assign csr_req_o   = (phase_q == PH_ACCESS) && !bad_q;
  assign csr_we_o    = write_q;
  assign csr_addr_o  = addr_q;
  assign csr_wdata_o = hwdata_i;

  assign hrdata_o    = csr_req_o ? csr_rdata_i : '0;
  assign hreadyout_o = !(((phase_q == PH_ACCESS) && xfer_err) || (phase_q == PH_ERR1));
  assign hresp_o     = (phase_q == PH_ERR1) || (phase_q == PH_ERR2);

  always_comb begin
    phase_d = phase_q;
    case (phase_q)
      PH_ACCESS: begin
        if (xfer_err) begin
          phase_d = PH_ERR1;
        end else begin
          phase_d = accept ? PH_ACCESS : PH_IDLE;
        end
      end
      PH_ERR1: phase_d = PH_ERR2;
      default: phase_d = accept ? PH_ACCESS : PH_IDLE;
    endcase
  end

  always_ff @(posedge hclk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      phase_q <= PH_IDLE;
    end else begin
      phase_q <= phase_d;
    end
  end

  // Address phase capture
  always_ff @(posedge hclk_i) begin
    if (accept) begin
      addr_q  <= haddr_i[csr_addr_width-1:0];
      write_q <= hwrite_i;
      bad_q   <= (haddr_i[1:0] != 2'b00) || (hsize_i > 3'd2);
    end
  end

  // A register block error turns into the two-cycle ERROR response
  a_err_two_cycle: assert property (@(posedge hclk_i) disable iff (!rst_n_i)
    (csr_req_o && csr_err_i) |-> !hreadyout_o ##1 (hresp_o && !hreadyout_o)
      ##1 (hresp_o && hreadyout_o));

endmodule

// File: hw/hci_queue_fifo.sv
// Depth must be a power of two of at least 4, and a threshold of 0 never triggers
`timescale 1ns/1ps

module hci_queue_fifo #(
  parameter int unsigned Depth      = 64,
  parameter bit          TrigOnFree = 1'b0
) (
  input  logic                                     hclk_i,
  input  logic                                     rst_n_i,
  input  logic                                     wvalid_i,
  input  logic [hci_queue_pkg::csr_data_width-1:0] wdata_i,
  input  logic                                     rready_i,
  input  logic                                     flush_i,
  input  logic [hci_queue_pkg::thld_width-1:0]     thld_i,
  output logic                                     wready_o,
  output logic                                     rvalid_o,
  output logic [hci_queue_pkg::csr_data_width-1:0] rdata_o,
  output logic                                     full_o,
  output logic                                     empty_o,
  output logic                                     thld_trig_o
);
  import hci_queue_pkg::*;

  localparam int unsigned PtrWidth = $clog2(Depth);
  localparam int unsigned CntWidth = $clog2(Depth + 1);

  logic [csr_data_width-1:0] mem_q [Depth];
  logic [PtrWidth-1:0]       wptr_q;
  logic [PtrWidth-1:0]       rptr_q;
  logic [CntWidth-1:0]       count_q;
  logic [CntWidth-1:0]       level;
  logic                      push;
  logic                      pop;

  assign full_o   = (count_q == CntWidth'(Depth));
  assign empty_o  = (count_q == '0);
  assign wready_o = !full_o;
  assign rvalid_o = !empty_o;
  assign rdata_o  = mem_q[rptr_q];

  assign push = wvalid_i && wready_o;
  assign pop  = rready_i && rvalid_o;

  always_ff @(posedge hclk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wptr_q  <= '0;
      rptr_q  <= '0;
      count_q <= '0;
    end else if (flush_i) begin
      wptr_q  <= '0;
      rptr_q  <= '0;
      count_q <= '0;
    end else begin
      if (push) begin
        wptr_q <= wptr_q + 1'b1;
      end
      if (pop) begin
        rptr_q <= rptr_q + 1'b1;
      end
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge hclk_i) begin
    if (push) begin
      mem_q[wptr_q] <= wdata_i;
    end
  end

  // Free entries for a queue the controller drains, used entries otherwise
  assign level       = TrigOnFree ? CntWidth'(Depth) - count_q : count_q;
  assign thld_trig_o = (thld_i != '0) && (32'(level) >= 32'(thld_i));

  // A word offered to a full queue is refused
  a_no_overflow: assert property (@(posedge hclk_i) disable iff (!rst_n_i)
    (full_o && wvalid_i && !rready_i && !flush_i) |=> (full_o && $stable(wptr_q)));

endmodule

// File: hw/hci_queue_csr.sv
// Narrow writes act as full words and the RESET_CONTROL flush bits clear themselves
`timescale 1ns/1ps

module hci_queue_csr (
  input  logic                                     hclk_i,
  input  logic                                     rst_n_i,
  input  logic                                     csr_req_i,
  input  logic                                     csr_we_i,
  input  logic [hci_queue_pkg::csr_addr_width-1:0] csr_addr_i,
  input  logic [hci_queue_pkg::csr_data_width-1:0] csr_wdata_i,
  input  logic                                     cmd_wready_i,
  input  logic                                     cmd_full_i,
  input  logic                                     cmd_empty_i,
  input  logic                                     resp_full_i,
  input  logic                                     resp_empty_i,
  input  logic                                     resp_rvalid_i,
  input  logic [hci_queue_pkg::csr_data_width-1:0] resp_rdata_i,
  output logic [hci_queue_pkg::csr_data_width-1:0] csr_rdata_o,
  output logic                                     csr_err_o,
  output logic                                     cmd_wvalid_o,
  output logic [hci_queue_pkg::csr_data_width-1:0] cmd_wdata_o,
  output logic                                     cmd_flush_o,
  output logic [hci_queue_pkg::thld_width-1:0]     cmd_thld_o,
  output logic                                     resp_rready_o,
  output logic                                     resp_flush_o,
  output logic [hci_queue_pkg::thld_width-1:0]     resp_thld_o
);
  import hci_queue_pkg::*;

  csr_reg_e              reg_sel;
  logic                  thld_we;
  logic [thld_width-1:0] cmd_thld_q;
  logic [thld_width-1:0] resp_thld_q;

  assign reg_sel     = csr_reg_e'(csr_addr_i);
  assign cmd_wdata_o = csr_wdata_i;
  assign cmd_thld_o  = cmd_thld_q;
  assign resp_thld_o = resp_thld_q;

  always_comb begin
    csr_rdata_o   = '0;
    csr_err_o     = 1'b0;
    cmd_wvalid_o  = 1'b0;
    resp_rready_o = 1'b0;
    cmd_flush_o   = 1'b0;
    resp_flush_o  = 1'b0;
    thld_we       = 1'b0;
    if (csr_req_i) begin
      case (reg_sel)
        REG_CMD_PORT: begin
          // Dropped when the queue is full
          if (!csr_we_i || !cmd_wready_i) begin
            csr_err_o = 1'b1;
          end else begin
            cmd_wvalid_o = 1'b1;
          end
        end
        REG_RESP_PORT: begin
          if (csr_we_i || !resp_rvalid_i) begin
            csr_err_o = 1'b1;
          end else begin
            csr_rdata_o   = resp_rdata_i;
            resp_rready_o = 1'b1;
          end
        end
        REG_QUEUE_THLD_CTRL: begin
          if (csr_we_i) begin
            thld_we = 1'b1;
          end else begin
            csr_rdata_o = {{(csr_data_width - 2 * thld_width){1'b0}}, resp_thld_q, cmd_thld_q};
          end
        end
        REG_QUEUE_STATUS: begin
          if (csr_we_i) begin
            csr_err_o = 1'b1;
          end else begin
            csr_rdata_o = {{(csr_data_width - 4){1'b0}},
                           resp_empty_i, resp_full_i, cmd_empty_i, cmd_full_i};
          end
        end
        REG_RESET_CONTROL: begin
          // Reads return zero
          if (csr_we_i) begin
            cmd_flush_o  = csr_wdata_i[1];
            resp_flush_o = csr_wdata_i[2];
          end
        end
        default: csr_err_o = 1'b1;
      endcase
    end
  end

  always_ff @(posedge hclk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cmd_thld_q  <= thld_reset_value;
      resp_thld_q <= thld_reset_value;
    end else if (thld_we) begin
      cmd_thld_q  <= csr_wdata_i[thld_width-1:0];
      resp_thld_q <= csr_wdata_i[2*thld_width-1:thld_width];
    end
  end

  // A flush leaves its queue empty on the next cycle
  a_cmd_flush_empties: assert property (@(posedge hclk_i) disable iff (!rst_n_i)
    cmd_flush_o |=> cmd_empty_i);
  a_resp_flush_empties: assert property (@(posedge hclk_i) disable iff (!rst_n_i)
    resp_flush_o |=> resp_empty_i);

endmodule

// File: hw/hci_queues_top.sv
// Queue depths must be powers of two of at least 4, and commands are single 32-bit words
`timescale 1ns/1ps

module hci_queues_top #(
  parameter int unsigned CmdFifoDepth  = 64,
  parameter int unsigned RespFifoDepth = 64
) (
  input  logic                                     hclk_i,
  input  logic                                     rst_n_i,
  // AHB-Lite slave
  input  logic                                     hsel_i,
  input  logic [31:0]                              haddr_i,
  input  logic [1:0]                               htrans_i,
  input  logic                                     hwrite_i,
  input  logic [2:0]                               hsize_i,
  input  logic [hci_queue_pkg::csr_data_width-1:0] hwdata_i,
  input  logic                                     hready_i,
  output logic [hci_queue_pkg::csr_data_width-1:0] hrdata_o,
  output logic                                     hreadyout_o,
  output logic                                     hresp_o,
  // Command queue, controller side
  output logic                                     hci_cmd_rvalid_o,
  input  logic                                     hci_cmd_rready_i,
  output logic [hci_queue_pkg::csr_data_width-1:0] hci_cmd_rdata_o,
  output logic                                     hci_cmd_full_o,
  output logic                                     hci_cmd_empty_o,
  output logic [hci_queue_pkg::thld_width-1:0]     hci_cmd_ready_thld_o,
  output logic                                     hci_cmd_ready_thld_trig_o,
  // Response queue, controller side
  input  logic                                     hci_resp_wvalid_i,
  output logic                                     hci_resp_wready_o,
  input  logic [hci_queue_pkg::csr_data_width-1:0] hci_resp_wdata_i,
  output logic                                     hci_resp_full_o,
  output logic                                     hci_resp_empty_o,
  output logic [hci_queue_pkg::thld_width-1:0]     hci_resp_ready_thld_o,
  output logic                                     hci_resp_ready_thld_trig_o
);
  import hci_queue_pkg::*;

  logic                      csr_req;
  logic                      csr_we;
  logic [csr_addr_width-1:0] csr_addr;
  logic [csr_data_width-1:0] csr_wdata;
  logic [csr_data_width-1:0] csr_rdata;
  logic                      csr_err;
  logic                      cmd_wvalid;
  logic [csr_data_width-1:0] cmd_wdata;
  logic                      cmd_wready;
  logic                      cmd_flush;
  logic                      resp_rready;
  logic                      resp_rvalid;
  logic [csr_data_width-1:0] resp_rdata;
  logic                      resp_flush;

  ahb_csr_bridge u_bridge (
    .hclk_i      (hclk_i),
    .rst_n_i     (rst_n_i),
    .hsel_i      (hsel_i),
    .haddr_i     (haddr_i),
    .htrans_i    (htrans_i),
    .hwrite_i    (hwrite_i),
    .hsize_i     (hsize_i),
    .hwdata_i    (hwdata_i),
    .hready_i    (hready_i),
    .csr_rdata_i (csr_rdata),
    .csr_err_i   (csr_err),
    .hrdata_o    (hrdata_o),
    .hreadyout_o (hreadyout_o),
    .hresp_o     (hresp_o),
    .csr_req_o   (csr_req),
    .csr_we_o    (csr_we),
    .csr_addr_o  (csr_addr),
    .csr_wdata_o (csr_wdata)
  );

  hci_queue_csr u_csr (
    .hclk_i        (hclk_i),
    .rst_n_i       (rst_n_i),
    .csr_req_i     (csr_req),
    .csr_we_i      (csr_we),
    .csr_addr_i    (csr_addr),
    .csr_wdata_i   (csr_wdata),
    .cmd_wready_i  (cmd_wready),
    .cmd_full_i    (hci_cmd_full_o),
    .cmd_empty_i   (hci_cmd_empty_o),
    .resp_full_i   (hci_resp_full_o),
    .resp_empty_i  (hci_resp_empty_o),
    .resp_rvalid_i (resp_rvalid),
    .resp_rdata_i  (resp_rdata),
    .csr_rdata_o   (csr_rdata),
    .csr_err_o     (csr_err),
    .cmd_wvalid_o  (cmd_wvalid),
    .cmd_wdata_o   (cmd_wdata),
    .cmd_flush_o   (cmd_flush),
    .cmd_thld_o    (hci_cmd_ready_thld_o),
    .resp_rready_o (resp_rready),
    .resp_flush_o  (resp_flush),
    .resp_thld_o   (hci_resp_ready_thld_o)
  );

  // Trigger on free space so the CPU knows it can queue more commands
  hci_queue_fifo #(
    .Depth      (CmdFifoDepth),
    .TrigOnFree (1'b1)
  ) u_cmd_fifo (
    .hclk_i      (hclk_i),
    .rst_n_i     (rst_n_i),
    .wvalid_i    (cmd_wvalid),
    .wdata_i     (cmd_wdata),
    .rready_i    (hci_cmd_rready_i),
    .flush_i     (cmd_flush),
    .thld_i      (hci_cmd_ready_thld_o),
    .wready_o    (cmd_wready),
    .rvalid_o    (hci_cmd_rvalid_o),
    .rdata_o     (hci_cmd_rdata_o),
    .full_o      (hci_cmd_full_o),
    .empty_o     (hci_cmd_empty_o),
    .thld_trig_o (hci_cmd_ready_thld_trig_o)
  );

  hci_queue_fifo #(
    .Depth      (RespFifoDepth),
    .TrigOnFree (1'b0)
  ) u_resp_fifo (
    .hclk_i      (hclk_i),
    .rst_n_i     (rst_n_i),
    .wvalid_i    (hci_resp_wvalid_i),
    .wdata_i     (hci_resp_wdata_i),
    .rready_i    (resp_rready),
    .flush_i     (resp_flush),
    .thld_i      (hci_resp_ready_thld_o),
    .wready_o    (hci_resp_wready_o),
    .rvalid_o    (resp_rvalid),
    .rdata_o     (resp_rdata),
    .full_o      (hci_resp_full_o),
    .empty_o     (hci_resp_empty_o),
    .thld_trig_o (hci_resp_ready_thld_trig_o)
  );

endmodule

// File: sim/hci_queue_checker.sv
// Models both queues, thresholds and AHB responses, sampled at the falling clock edge
`timescale 1ns/1ps

module hci_queue_checker #(
  parameter int unsigned Depth = 8
) (
  input  logic         clk_i,
  input  logic         rst_n_i,
  input  logic [127:0] test_name_i,
  input  logic [31:0]  exp_data_i,
  input  logic         exp_err_i,
  input  logic         hsel_i,
  input  logic [31:0]  haddr_i,
  input  logic [1:0]   htrans_i,
  input  logic         hwrite_i,
  input  logic [31:0]  hwdata_i,
  input  logic         hready_i,
  input  logic [31:0]  hrdata_i,
  input  logic         hreadyout_i,
  input  logic         hresp_i,
  input  logic         cmd_rvalid_i,
  input  logic         cmd_rready_i,
  input  logic [31:0]  cmd_rdata_i,
  input  logic         cmd_full_i,
  input  logic         cmd_empty_i,
  input  logic [7:0]   cmd_thld_i,
  input  logic         cmd_trig_i,
  input  logic         resp_wvalid_i,
  input  logic         resp_wready_i,
  input  logic [31:0]  resp_wdata_i,
  input  logic         resp_full_i,
  input  logic         resp_empty_i,
  input  logic [7:0]   resp_thld_i,
  input  logic         resp_trig_i,
  output int           err_count_o
);
  logic [31:0] cmd_q [$];
  logic [31:0] resp_q [$];
  logic [7:0]  cmd_thld;
  logic [7:0]  resp_thld;
  logic        dphase;
  logic [7:0]  daddr;
  logic        dwrite;
  int          err_stage;
  int          errors = 0;

  assign err_count_o = errors;

  function automatic logic trig_on(input int level, input logic [7:0] thld);
    return (thld != 8'd0) && (level >= int'(thld));
  endfunction

  task automatic compare_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
    if (expected !== actual) begin
      errors++;
      $display("CHECK FAILED %s %s: expected %h, actual %h",
               string'(test_name_i), what, expected, actual);
    end
  endtask

  always @(negedge clk_i) begin
    logic        m_err;
    logic [31:0] m_rdata;
    logic [3:0]  m_status;
    logic        cpu_push;
    logic        cpu_pop;
    logic        cmd_pop;
    logic        resp_push;
    logic        cmd_flush;
    logic        resp_flush;
    logic        thld_we;
    if (!rst_n_i) begin
      cmd_q.delete();
      resp_q.delete();
      cmd_thld  = 8'd1;
      resp_thld = 8'd1;
      dphase    = 1'b0;
      err_stage = 0;
    end else begin
      m_status = {resp_q.size() == 0, resp_q.size() == Depth,
                  cmd_q.size() == 0, cmd_q.size() == Depth};
      compare_value("cmd flags",
                    32'({m_status[0], m_status[1], cmd_q.size() != 0,
                         trig_on(int'(Depth) - cmd_q.size(), cmd_thld)}),
                    32'({cmd_full_i, cmd_empty_i, cmd_rvalid_i, cmd_trig_i}));
      compare_value("resp flags",
                    32'({m_status[2], m_status[3], !m_status[2],
                         trig_on(resp_q.size(), resp_thld)}),
                    32'({resp_full_i, resp_empty_i, resp_wready_i, resp_trig_i}));
      compare_value("thresholds", {16'h0, resp_thld, cmd_thld}, {16'h0, resp_thld_i, cmd_thld_i});

      m_err      = 1'b0;
      m_rdata    = '0;
      cpu_push   = 1'b0;
      cpu_pop    = 1'b0;
      cmd_flush  = 1'b0;
      resp_flush = 1'b0;
      thld_we    = 1'b0;
      // One wait cycle, then the two ERROR cycles
      if (err_stage == 1) begin
        compare_value("error cycle 1", 32'(2'b10), 32'({hresp_i, hreadyout_i}));
        err_stage = 2;
      end else if (err_stage == 2) begin
        compare_value("error cycle 2", 32'(2'b11), 32'({hresp_i, hreadyout_i}));
        err_stage = 0;
      end else if (dphase) begin
        case (daddr)
          8'h00: begin
            if (dwrite && cmd_q.size() < Depth) begin
              cpu_push = 1'b1;
            end else begin
              m_err = 1'b1;
            end
          end
          8'h04: begin
            if (!dwrite && resp_q.size() != 0) begin
              m_rdata = resp_q[0];
              cpu_pop = 1'b1;
            end else begin
              m_err = 1'b1;
            end
          end
          8'h08: begin
            if (dwrite) begin
              thld_we = 1'b1;
            end else begin
              m_rdata = {16'h0, resp_thld, cmd_thld};
            end
          end
          8'h0c: begin
            if (dwrite) begin
              m_err = 1'b1;
            end else begin
              m_rdata = {28'h0, m_status};
            end
          end
          8'h10: begin
            if (dwrite) begin
              cmd_flush  = hwdata_i[1];
              resp_flush = hwdata_i[2];
            end
          end
          default: m_err = 1'b1;
        endcase
        compare_value("error", 32'(exp_err_i), 32'(!hreadyout_i));
        compare_value("data phase", m_err ? 32'h0 : 32'h1, 32'({hresp_i, hreadyout_i}));
        if (!dwrite && !m_err) begin
          compare_value("read data", exp_data_i, hrdata_i);
          compare_value("model read data", m_rdata, hrdata_i);
        end
        if (m_err) begin
          err_stage = 1;
        end
      end else begin
        compare_value("idle bus", 32'h1, 32'({hresp_i, hreadyout_i}));
      end

      dphase = hsel_i && hready_i && htrans_i[1] && hreadyout_i;
      daddr  = haddr_i[7:0];
      dwrite = hwrite_i;

      cmd_pop = cmd_rvalid_i && cmd_rready_i && (cmd_q.size() != 0);
      if (cmd_rvalid_i && cmd_rready_i) begin
        compare_value("command word", exp_data_i, cmd_rdata_i);
        if (cmd_pop) begin
          compare_value("model command word", cmd_q[0], cmd_rdata_i);
        end
      end
      resp_push = resp_wvalid_i && (resp_q.size() < Depth);

      // Flush wins over a push or pop on the same edge
      if (cmd_flush) begin
        cmd_q.delete();
      end else begin
        if (cmd_pop) begin
          void'(cmd_q.pop_front());
        end
        if (cpu_push) begin
          cmd_q.push_back(hwdata_i);
        end
      end
      if (resp_flush) begin
        resp_q.delete();
      end else begin
        if (cpu_pop) begin
          void'(resp_q.pop_front());
        end
        if (resp_push) begin
          resp_q.push_back(resp_wdata_i);
        end
      end
      if (thld_we) begin
        {resp_thld, cmd_thld} = hwdata_i[15:0];
      end
    end
  end

endmodule

// File: sim/tb_hci_queues.sv
// Runs the steps of sim/hci_queues_input.txt from the project root with both queues 8 deep
`timescale 1ns/1ps

module tb_hci_queues;
  localparam int unsigned QueueDepth = 8;

  logic         clk;
  logic         rst_n;
  logic         hsel;
  logic [31:0]  haddr;
  logic [1:0]   htrans;
  logic         hwrite;
  logic [2:0]   hsize;
  logic [31:0]  hwdata;
  logic         hready;
  logic [31:0]  hrdata;
  logic         hreadyout;
  logic         hresp;
  logic         cmd_rvalid;
  logic         cmd_rready;
  logic [31:0]  cmd_rdata;
  logic         cmd_full;
  logic         cmd_empty;
  logic [7:0]   cmd_thld;
  logic         cmd_trig;
  logic         resp_wvalid;
  logic         resp_wready;
  logic [31:0]  resp_wdata;
  logic         resp_full;
  logic         resp_empty;
  logic [7:0]   resp_thld;
  logic         resp_trig;
  logic [127:0] test_name;
  logic [31:0]  exp_data;
  logic         exp_err;
  int           chk_errors;
  int           run_errors;
  int           steps;
  bit           timed_out;

  // Single slave on the bus
  assign hready = hreadyout;

  always #20 clk = ~clk;

  hci_queues_top #(
    .CmdFifoDepth  (QueueDepth),
    .RespFifoDepth (QueueDepth)
  ) UUT (
    .hclk_i                     (clk),
    .rst_n_i                    (rst_n),
    .hsel_i                     (hsel),
    .haddr_i                    (haddr),
    .htrans_i                   (htrans),
    .hwrite_i                   (hwrite),
    .hsize_i                    (hsize),
    .hwdata_i                   (hwdata),
    .hready_i                   (hready),
    .hrdata_o                   (hrdata),
    .hreadyout_o                (hreadyout),
    .hresp_o                    (hresp),
    .hci_cmd_rvalid_o           (cmd_rvalid),
    .hci_cmd_rready_i           (cmd_rready),
    .hci_cmd_rdata_o            (cmd_rdata),
    .hci_cmd_full_o             (cmd_full),
    .hci_cmd_empty_o            (cmd_empty),
    .hci_cmd_ready_thld_o       (cmd_thld),
    .hci_cmd_ready_thld_trig_o  (cmd_trig),
    .hci_resp_wvalid_i          (resp_wvalid),
    .hci_resp_wready_o          (resp_wready),
    .hci_resp_wdata_i           (resp_wdata),
    .hci_resp_full_o            (resp_full),
    .hci_resp_empty_o           (resp_empty),
    .hci_resp_ready_thld_o      (resp_thld),
    .hci_resp_ready_thld_trig_o (resp_trig)
  );

  hci_queue_checker #(
    .Depth (QueueDepth)
  ) u_checker (
    .clk_i         (clk),
    .rst_n_i       (rst_n),
    .test_name_i   (test_name),
    .exp_data_i    (exp_data),
    .exp_err_i     (exp_err),
    .hsel_i        (hsel),
    .haddr_i       (haddr),
    .htrans_i      (htrans),
    .hwrite_i      (hwrite),
    .hwdata_i      (hwdata),
    .hready_i      (hready),
    .hrdata_i      (hrdata),
    .hreadyout_i   (hreadyout),
    .hresp_i       (hresp),
    .cmd_rvalid_i  (cmd_rvalid),
    .cmd_rready_i  (cmd_rready),
    .cmd_rdata_i   (cmd_rdata),
    .cmd_full_i    (cmd_full),
    .cmd_empty_i   (cmd_empty),
    .cmd_thld_i    (cmd_thld),
    .cmd_trig_i    (cmd_trig),
    .resp_wvalid_i (resp_wvalid),
    .resp_wready_i (resp_wready),
    .resp_wdata_i  (resp_wdata),
    .resp_full_i   (resp_full),
    .resp_empty_i  (resp_empty),
    .resp_thld_i   (resp_thld),
    .resp_trig_i   (resp_trig),
    .err_count_o   (chk_errors)
  );

  task automatic report_timeout(input string what);
    $display("Timeout in step %s: %s", string'(test_name), what);
    run_errors++;
    timed_out = 1'b1;
  endtask

  // Called on a rising edge, returns at the falling edge of the last data phase cycle
  task automatic ahb_xfer(input logic write, input logic [31:0] addr, input logic [31:0] data);
    int n;
    n = 0;
    hsel   <= 1'b1;
    haddr  <= addr;
    htrans <= 2'b10;
    hwrite <= write;
    @(posedge clk);
    hsel   <= 1'b0;
    htrans <= 2'b00;
    hwdata <= data;
    @(negedge clk);
    while (!hreadyout && n < 8) begin
      @(negedge clk);
      n++;
    end
    if (!hreadyout) begin
      report_timeout("AHB data phase never completed");
    end
  endtask

  task automatic push_resp(input logic [31:0] word);
    int n;
    n = 0;
    resp_wvalid <= 1'b1;
    resp_wdata  <= word;
    @(negedge clk);
    while (!resp_wready && n < 16) begin
      @(negedge clk);
      n++;
    end
    if (!resp_wready) begin
      report_timeout("response queue never became ready");
    end
    @(posedge clk);
    resp_wvalid <= 1'b0;
  endtask

  task automatic pop_cmd;
    int n;
    n = 0;
    @(negedge clk);
    while (!cmd_rvalid && n < 16) begin
      @(negedge clk);
      n++;
    end
    if (!cmd_rvalid) begin
      report_timeout("no command became valid");
    end else begin
      @(posedge clk);
      cmd_rready <= 1'b1;
      @(posedge clk);
      cmd_rready <= 1'b0;
    end
  endtask

  task automatic run_step(input logic [127:0] name, input string op, input logic [31:0] adr,
                          input logic [31:0] word, input logic err);
    @(posedge clk);
    test_name <= name;
    exp_data  <= word;
    exp_err   <= err;
    if (op == "WR") begin
      ahb_xfer(1'b1, adr, word);
    end else if (op == "RD") begin
      ahb_xfer(1'b0, adr, 32'h0);
    end else if (op == "PUSH") begin
      push_resp(word);
    end else if (op == "POP") begin
      pop_cmd();
    end else if (op != "IDLE") begin
      $display("Unknown operation %s in the stimulus file", op);
      run_errors++;
    end
  endtask

  initial begin
    int           fd;
    int           got;
    int           i;
    string        line;
    logic [127:0] f_name;
    logic [63:0]  f_op;
    logic [31:0]  f_adr;
    logic [31:0]  f_word;
    logic         f_err;
    int           f_cnt;
    clk         = 1'b0;
    rst_n       = 1'b0;
    hsel        = 1'b0;
    haddr       = '0;
    htrans      = 2'b00;
    hwrite      = 1'b0;
    hsize       = 3'd2;
    hwdata      = '0;
    cmd_rready  = 1'b0;
    resp_wvalid = 1'b0;
    resp_wdata  = '0;
    test_name   = "reset";
    exp_data    = '0;
    exp_err     = 1'b0;
    run_errors  = 0;
    steps       = 0;
    timed_out   = 1'b0;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    fd = $fopen("sim/hci_queues_input.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the stimulus file sim/hci_queues_input.txt");
      run_errors++;
    end else begin
      while (!timed_out && $fgets(line, fd) != 0) begin
        got = $sscanf(line, "%s %s %h %h %h %d", f_name, f_op, f_adr, f_word, f_err, f_cnt);
        // Comment and blank lines do not parse into six fields
        if (got == 6) begin
          steps++;
          for (i = 0; i < f_cnt && !timed_out; i++) begin
            run_step(f_name, string'(f_op), f_adr, f_word + i, f_err);
          end
        end
      end
      $fclose(fd);
      if (steps == 0) begin
        $display("The stimulus file holds no steps");
        run_errors++;
      end
    end
    repeat (3) @(posedge clk);
    $display("Errors: %0d check, %0d run", chk_errors, run_errors);
    if (chk_errors == 0 && run_errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: sim/hci_queues_input.txt
# test op adr word err cnt
# adr and word in hex, cnt repeats the step with word stepping by one
rst_stat   RD   0c 0000000a 0 1
rst_thld   RD   08 00000101 0 1
cmd_fill   WR   00 c0000001 0 8
cmd_full   RD   0c 00000009 0 1
cmd_over   WR   00 c00000ff 1 1
cmd_drain  POP  00 c0000001 0 8
cmd_empty  RD   0c 0000000a 0 1
resp_fill  PUSH 00 a0000001 0 8
resp_full  RD   0c 00000006 0 1
resp_drain RD   04 a0000001 0 8
resp_under RD   04 00000000 1 1
thld_set   WR   08 00000305 0 1
thld_read  RD   08 00000305 0 1
resp_lvl   PUSH 00 b0000001 0 4
cmd_lvl    WR   00 d0000001 0 4
flush_cmd  WR   10 00000002 0 1
stat_fl1   RD   0c 00000002 0 1
flush_resp WR   10 00000004 0 1
rst_ctrl   RD   10 00000000 0 1
stat_fl2   RD   0c 0000000a 0 1
thld_zero  WR   08 00000000 0 1
zero_push  PUSH 00 e0000001 0 2
zero_cmd   WR   00 f0000001 0 2
bad_offset RD   14 00000000 1 1
bad_read   RD   00 00000000 1 1
bad_write  WR   0c 00000000 1 1
tail       IDLE 00 00000000 0 4

// File: tb.f
hw/hci_queue_pkg.sv
hw/ahb_csr_bridge.sv
hw/hci_queue_fifo.sv
hw/hci_queue_csr.sv
hw/hci_queues_top.sv
sim/hci_queue_checker.sv
sim/tb_hci_queues.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module tb_hci_queues -f tb.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vtb_hci_queues > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "TESTS FAILED" "$LOG"; then
  exit 1
fi
exit 0
